/* project.f */
+incdir+design
design/ymplayer_pkg.sv
design/rom_wr_if.sv
design/rst_sync.sv
design/rom_loader.sv
design/song_rom.sv
design/song_player.sv
design/ymplayer_top.sv
dv/ymplayer_assertions.sv
dv/ymplayer_tb.sv

/* Bender.yml */
package:
  name: ymplayer

sources:
  - include_dirs:
      - design
    files:
      - design/ymplayer_pkg.sv
      - design/rom_wr_if.sv
      - design/rst_sync.sv
      - design/rom_loader.sv
      - design/song_rom.sv
      - design/song_player.sv
      - design/ymplayer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/ymplayer_assertions.sv
      - dv/ymplayer_tb.sv

/* dv/ymplayer_tb.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

module ymplayer_tb import ymplayer_pkg::*; ();

	localparam int N_SONGS     = 7;
	localparam int MAX_CMD     = 6;
	localparam int MODE_STEADY = 0;
	localparam int MODE_GAPS   = 1;
	localparam int MODE_BURST  = 2;

	logic       clk_per;
	logic       arst_n;
	logic       byte_valid;
	logic [7:0] byte_data;
	logic       credit_return;
	logic       credit_error;
	logic       play;
	logic       load_done;
	logic       opm_wr;
	logic [7:0] opm_addr;
	logic [7:0] opm_data;
	logic       song_done;

	// song table, one row per song image
	string      song_name [N_SONGS];
	int         send_mode [N_SONGS];
	bit         late_play [N_SONGS];
	int         pad_len   [N_SONGS];
	int         n_cmd     [N_SONGS];
	player_op_e cmd_op    [N_SONGS][MAX_CMD];
	logic [7:0] cmd_b1    [N_SONGS][MAX_CMD];
	logic [7:0] cmd_b2    [N_SONGS][MAX_CMD];

	// what the monitor saw on the sound chip port
	logic [7:0] seen_addr [$];
	logic [7:0] seen_data [$];
	longint     seen_cyc  [$];
	longint     cycle;
	int         returns_seen;
	int         early_writes;
	int         mismatches;
	int         wd_limit_ns;

	ymplayer_top DUT (.*);

	bind ymplayer_top ymplayer_assertions u_assert (
		.clk_per       (clk_per),
		.arst_n        (rst_n_sync),
		.byte_accept   (u_loader.push),
		.credit_return (credit_return),
		.opm_wr        (opm_wr),
		.load_done     (load_done),
		.song_done     (song_done),
		.rom_wr_en     (u_rom_wr.wr_en)
	);

	always #5 clk_per = ~clk_per;

	always @(posedge clk_per) begin
		cycle <= cycle + 1;
	end

	always @(negedge clk_per) begin
		if (opm_wr) begin
			seen_addr.push_back(opm_addr);
			seen_data.push_back(opm_data);
			seen_cyc.push_back(cycle);
			if (!load_done) begin
				early_writes++;
			end
		end
		if (credit_return) begin
			returns_seen++;
		end
	end

	task automatic check_write(input string name, input logic [7:0] exp_addr,
			input logic [7:0] exp_data, input logic [7:0] act_addr, input logic [7:0] act_data);
		if (exp_addr !== act_addr || exp_data !== act_data) begin
			mismatches++;
			$display("MISMATCH %s: expected write %02h=%02h, actual %02h=%02h",
				name, exp_addr, exp_data, act_addr, act_data);
		end
	endtask

	task automatic check_flag(input string name, input logic exp_bit, input logic act_bit);
		if (exp_bit !== act_bit) begin
			mismatches++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp_bit, act_bit);
		end
	endtask

	task automatic check_count(input string name, input int exp_val, input int act_val,
			input bit at_least);
		if (at_least ? (act_val < exp_val) : (act_val != exp_val)) begin
			mismatches++;
			$display("MISMATCH %s: expected %s%0d, actual %0d", name,
				at_least ? ">=" : "", exp_val, act_val);
		end
	endtask

	task automatic set_song(input int s, input string name, input int mode, input bit late,
			input int pad);
		song_name[s] = name;
		send_mode[s] = mode;
		late_play[s] = late;
		pad_len[s]   = pad;
		n_cmd[s]     = 0;
	endtask

	task automatic add_cmd(input int s, input player_op_e op, input logic [7:0] b1,
			input logic [7:0] b2);
		cmd_op[s][n_cmd[s]] = op;
		cmd_b1[s][n_cmd[s]] = b1;
		cmd_b2[s][n_cmd[s]] = b2;
		n_cmd[s]++;
	endtask

	task automatic build_table();
		set_song(0, "writes", MODE_STEADY, 1'b0, 0);
		add_cmd(0, OP_WRITE, 8'h10, 8'ha1);
		add_cmd(0, OP_WRITE, 8'h20, 8'hb2);
		add_cmd(0, OP_WRITE, 8'h30, 8'hc3);
		add_cmd(0, OP_END, 8'h00, 8'h00);
		set_song(1, "waits", MODE_STEADY, 1'b0, 0);
		add_cmd(1, OP_WRITE, 8'h08, 8'h11);
		add_cmd(1, OP_WAIT, 8'h00, 8'h03);
		add_cmd(1, OP_WRITE, 8'h08, 8'h22);
		add_cmd(1, OP_WRITE, 8'h08, 8'h33);
		add_cmd(1, OP_WAIT, 8'h00, 8'h00);
		add_cmd(1, OP_WRITE, 8'h28, 8'h44);
		set_song(2, "credits", MODE_GAPS, 1'b1, 0);
		add_cmd(2, OP_WRITE, 8'h40, 8'h01);
		add_cmd(2, OP_WRITE, 8'h41, 8'h02);
		add_cmd(2, OP_END, 8'h00, 8'h00);
		// length 4 makes the image YM_CREDITS + 2 bytes
		set_song(3, "violation", MODE_BURST, 1'b0, 1);
		add_cmd(3, OP_WRITE, 8'h50, 8'h55);
		// last command cut short by the length
		set_song(4, "no_end", MODE_STEADY, 1'b0, 2);
		add_cmd(4, OP_WRITE, 8'h60, 8'h01);
		add_cmd(4, OP_WRITE, 8'h61, 8'h02);
		set_song(5, "bad_opcode", MODE_STEADY, 1'b0, 0);
		add_cmd(5, OP_WRITE, 8'h70, 8'h01);
		add_cmd(5, player_op_e'(8'h7f), 8'h71, 8'h02);
		add_cmd(5, OP_WRITE, 8'h72, 8'h03);
		add_cmd(5, OP_END, 8'h00, 8'h00);
		set_song(6, "zero_len", MODE_STEADY, 1'b0, 0);
	endtask

	function automatic int song_budget(input int s);
		int clocks;
		clocks = (2 + 3 * n_cmd[s] + pad_len[s]) * 4 + n_cmd[s] * 8;
		for (int i = 0; i < n_cmd[s]; i++) begin
			if (cmd_op[s][i] == OP_WAIT) begin
				clocks += {cmd_b1[s][i], cmd_b2[s][i]} * `YM_WAIT_TICK;
			end
		end
		return clocks * 10;
	endfunction

	task automatic apply_reset();
		@(negedge clk_per);
		arst_n     = 1'b0;
		byte_valid = 1'b0;
		byte_data  = 8'h00;
		play       = 1'b0;
		repeat (2) @(negedge clk_per);
		arst_n = 1'b1;
		// synchroniser releases two clocks later
		repeat (3) @(negedge clk_per);
	endtask

	task automatic send_image(input logic [7:0] image [$], input int mode,
			output bit exp_err, output int accepted);
		int credits;
		int occ;
		int idx;
		bit go;
		bit full;
		credits  = `YM_CREDITS;
		occ      = 0;
		idx      = 0;
		exp_err  = 1'b0;
		accepted = 0;
		while (idx < image.size()) begin
			@(negedge clk_per);
			if (mode == MODE_BURST) begin
				go = 1'b1;
			end else if (mode == MODE_GAPS) begin
				go = (credits > 0) && ($urandom % 3 != 0);
			end else begin
				go = (credits > 0);
			end
			// loader buffer drains one byte per clock
			full = (occ == `YM_CREDITS);
			if (go && full) begin
				exp_err = 1'b1;
			end
			if (go && !full) begin
				accepted++;
			end
			occ = occ + ((go && !full) ? 1 : 0) - ((occ != 0) ? 1 : 0);
			// credit seen now is usable from the next byte on
			if (credit_return) begin
				credits++;
			end
			byte_valid = go;
			byte_data  = go ? image[idx] : 8'h00;
			if (go) begin
				idx++;
				credits--;
			end
		end
		@(negedge clk_per);
		byte_valid = 1'b0;
	endtask

	task automatic run_song(input int s);
		logic [7:0] image    [$];
		logic [7:0] exp_addr [$];
		logic [7:0] exp_data [$];
		int         exp_gap  [$];
		bit         exp_min  [$];
		int         len;
		int         gap;
		int         accepted;
		bit         waited;
		bit         stop;
		bit         exp_err;
		int         i;
		len = n_cmd[s] * 3 + pad_len[s];
		image.push_back(8'(len >> 8));
		image.push_back(8'(len));
		for (i = 0; i < n_cmd[s]; i++) begin
			image.push_back(8'(cmd_op[s][i]));
			image.push_back(cmd_b1[s][i]);
			image.push_back(cmd_b2[s][i]);
		end
		repeat (pad_len[s]) image.push_back(8'hee);

		// expected writes and gaps, four clocks per command plus waits
		gap    = 0;
		waited = 1'b0;
		stop   = 1'b0;
		i      = 0;
		while (i < n_cmd[s] && !stop) begin
			if (3 * i + 3 > len) begin
				stop = 1'b1;
			end else begin
				gap += 4;
				if (cmd_op[s][i] == OP_WRITE) begin
					exp_addr.push_back(cmd_b1[s][i]);
					exp_data.push_back(cmd_b2[s][i]);
					exp_gap.push_back(gap);
					exp_min.push_back(waited);
					gap    = 0;
					waited = 1'b0;
				end else if (cmd_op[s][i] == OP_WAIT) begin
					gap += {cmd_b1[s][i], cmd_b2[s][i]} * `YM_WAIT_TICK;
					waited = 1'b1;
				end else begin
					stop = 1'b1;
				end
			end
			i++;
		end

		apply_reset();
		seen_addr.delete();
		seen_data.delete();
		seen_cyc.delete();
		returns_seen = 0;
		early_writes = 0;
		play         = !late_play[s];
		send_image(image, send_mode[s], exp_err, accepted);
		while (returns_seen < accepted) @(posedge clk_per);
		repeat (2) @(negedge clk_per);
		check_flag({song_name[s], " load_done"}, 1'b1, load_done);
		check_flag({song_name[s], " credit_error"}, exp_err, credit_error);
		check_count({song_name[s], " credits returned"}, accepted, returns_seen, 1'b0);

		if (late_play[s]) begin
			repeat (20) @(negedge clk_per);
			check_count({song_name[s], " writes before play"}, 0, seen_addr.size(), 1'b0);
			check_flag({song_name[s], " song_done before play"}, 1'b0, song_done);
			@(negedge clk_per);
			play = 1'b1;
		end

		while (!song_done) @(negedge clk_per);
		// no writes may follow the stop
		repeat (12) @(negedge clk_per);
		check_flag({song_name[s], " song_done"}, 1'b1, song_done);
		@(posedge clk_per);
		check_count({song_name[s], " writes before load"}, 0, early_writes, 1'b0);
		check_count({song_name[s], " write count"}, exp_addr.size(), seen_addr.size(), 1'b0);
		for (i = 0; i < exp_addr.size() && i < seen_addr.size(); i++) begin
			check_write($sformatf("%s write %0d", song_name[s], i), exp_addr[i], exp_data[i],
				seen_addr[i], seen_data[i]);
			if (i > 0) begin
				check_count($sformatf("%s gap %0d", song_name[s], i), exp_gap[i],
					int'(seen_cyc[i] - seen_cyc[i-1]), exp_min[i]);
			end
		end
	endtask

	initial begin
		int budget;
		clk_per      = 1'b0;
		arst_n       = 1'b0;
		byte_valid   = 1'b0;
		byte_data    = 8'h00;
		play         = 1'b0;
		cycle        = 0;
		returns_seen = 0;
		early_writes = 0;
		mismatches   = 0;
		void'($urandom(32'hf26c));
		build_table();
		budget = 0;
		for (int s = 0; s < N_SONGS; s++) begin
			budget += song_budget(s);
		end
		// reset, late play and tail clocks per song
		wd_limit_ns = budget + N_SONGS * 1500;

		for (int s = 0; s < N_SONGS; s++) begin
			run_song(s);
		end

		$display("errors: %0d mismatches, %0d assertion failures",
			mismatches, DUT.u_assert.fail_count);
		if (mismatches == 0 && DUT.u_assert.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		wait (wd_limit_ns > 0);
		#(wd_limit_ns);
		$display("timeout: the song tests did not finish within %0d ns", wd_limit_ns);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

/* dv/ymplayer_assertions.sv */
`timescale 1ns/1ps

module ymplayer_assertions import ymplayer_pkg::*; (
	input logic          clk_per,
	input logic          arst_n,
	input logic          byte_accept,
	input logic          credit_return,
	input logic          opm_wr,
	input logic          load_done,
	input logic          song_done,
	input logic          rom_wr_en
);

	// number of failed assertions so far
	int fail_count = 0;
	int accepted_q;
	int returned_q;

	always_ff @(posedge clk_per or negedge arst_n) begin
		if (!arst_n) begin
			accepted_q <= 0;
			returned_q <= 0;
		end else begin
			if (byte_accept) begin
				accepted_q <= accepted_q + 1;
			end
			if (credit_return) begin
				returned_q <= returned_q + 1;
			end
		end
	end

	// each credit pulse pops a byte that came in on an earlier clock
	credit_bound: assert property (@(posedge clk_per) disable iff (!arst_n)
		credit_return |-> (returned_q < accepted_q))
	else begin
		$error("credit returned without a matching accepted byte");
		fail_count++;
	end

	opm_pulse: assert property (@(posedge clk_per) disable iff (!arst_n)
		opm_wr |=> !opm_wr)
	else begin
		$error("opm_wr held for more than one clock");
		fail_count++;
	end

	load_sticky: assert property (@(posedge clk_per) disable iff (!arst_n)
		load_done |=> load_done)
	else begin
		$error("load_done fell without reset");
		fail_count++;
	end

	done_sticky: assert property (@(posedge clk_per) disable iff (!arst_n)
		song_done |=> song_done)
	else begin
		$error("song_done fell without reset");
		fail_count++;
	end

	// the ROM image is frozen once loading is done
	no_late_write: assert property (@(posedge clk_per) disable iff (!arst_n)
		load_done |=> !rom_wr_en)
	else begin
		$error("ROM write after load_done");
		fail_count++;
	end

endmodule

/* design/ymplayer_top.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

module ymplayer_top (
	input  logic       clk_per,
	input  logic       arst_n,
	// host byte link
	input  logic       byte_valid,
	input  logic [7:0] byte_data,
	output logic       credit_return,
	output logic       credit_error,
	// player control
	input  logic       play,
	output logic       load_done,
	// sound chip register writes
	output logic       opm_wr,
	output logic [7:0] opm_addr,
	output logic [7:0] opm_data,
	output logic       song_done
);

	logic                  rst_n_sync;
	logic [`YM_ROM_AW:0]   song_len;
	logic [`YM_ROM_AW-1:0] rd_addr;
	logic [7:0]            rd_data;

	rom_wr_if u_rom_wr ();

	rst_sync u_rst_sync (
		.clk_per    (clk_per),
		.arst_n     (arst_n),
		.rst_n_sync (rst_n_sync)
	);

	rom_loader u_loader (
		.clk_per       (clk_per),
		.arst_n        (rst_n_sync),
		.byte_valid    (byte_valid),
		.byte_data     (byte_data),
		.credit_return (credit_return),
		.credit_error  (credit_error),
		.load_done     (load_done),
		.song_len      (song_len),
		.wr            (u_rom_wr)
	);

	song_rom u_rom (
		.clk_per (clk_per),
		.wr      (u_rom_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	song_player u_player (
		.clk_per   (clk_per),
		.arst_n    (rst_n_sync),
		.play      (play),
		.load_done (load_done),
		.song_len  (song_len),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data),
		.opm_wr    (opm_wr),
		.opm_addr  (opm_addr),
		.opm_data  (opm_data),
		.song_done (song_done)
	);

endmodule

/* design/song_player.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

module song_player import ymplayer_pkg::*; (
	input  logic                  clk_per,
	input  logic                  arst_n,
	input  logic                  play,
	input  logic                  load_done,
	input  logic [`YM_ROM_AW:0]   song_len,
	output logic [`YM_ROM_AW-1:0] rd_addr,
	input  logic [7:0]            rd_data,
	output logic                  opm_wr,
	output logic [7:0]            opm_addr,
	output logic [7:0]            opm_data,
	output logic                  song_done
);

	localparam int TICK_W = $clog2(`YM_WAIT_TICK + 1);

	player_state_e         state_q;
	logic [`YM_ROM_AW:0]   addr_q;
	logic [`YM_ROM_AW+1:0] cmd_end;
	player_op_e            op_q;
	logic [7:0]            b1_q;
	logic [15:0]           ticks_q;
	logic [TICK_W-1:0]     tick_cnt_q;
	logic [15:0]           wait_count;
	logic                  tick_done;

	// address one past the command about to be fetched
	assign cmd_end    = {1'b0, addr_q} + 3'd3;
	assign rd_addr    = addr_q[`YM_ROM_AW-1:0];
	// byte 2 is on rd_data during PL_EXEC
	assign wait_count = {b1_q, rd_data};
	assign tick_done  = (tick_cnt_q == TICK_W'(`YM_WAIT_TICK - 1));
	assign song_done  = (state_q == PL_END);

	always_ff @(posedge clk_per or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= PL_IDLE;
			addr_q     <= '0;
			ticks_q    <= '0;
			tick_cnt_q <= '0;
			opm_wr     <= 1'b0;
		end else begin
			opm_wr <= 1'b0;
			case (state_q)
				PL_IDLE: begin
					addr_q <= '0;
					if (load_done && play) begin
						state_q <= PL_FETCH_OP;
					end
				end
				PL_FETCH_OP: begin
					// a command cut short by the length ends the song
					if (cmd_end > song_len) begin
						state_q <= PL_END;
					end else begin
						addr_q  <= addr_q + 1'b1;
						state_q <= PL_FETCH_B1;
					end
				end
				PL_FETCH_B1: begin
					addr_q  <= addr_q + 1'b1;
					state_q <= PL_FETCH_B2;
				end
				PL_FETCH_B2: begin
					addr_q  <= addr_q + 1'b1;
					state_q <= PL_EXEC;
				end
				PL_EXEC: begin
					case (op_q)
						OP_WRITE: begin
							opm_wr  <= 1'b1;
							state_q <= PL_FETCH_OP;
						end
						OP_WAIT: begin
							tick_cnt_q <= '0;
							ticks_q    <= wait_count;
							state_q    <= (wait_count == '0) ? PL_FETCH_OP : PL_WAIT;
						end
						// OP_END and unknown opcodes
						default: begin
							state_q <= PL_END;
						end
					endcase
				end
				PL_WAIT: begin
					if (tick_done) begin
						tick_cnt_q <= '0;
						ticks_q    <= ticks_q - 1'b1;
						if (ticks_q == 16'd1) begin
							state_q <= PL_FETCH_OP;
						end
					end else begin
						tick_cnt_q <= tick_cnt_q + 1'b1;
					end
				end
				// PL_END holds until reset
				default: begin
					state_q <= PL_END;
				end
			endcase
		end
	end

	// command bytes trail the read address by one clock
	always_ff @(posedge clk_per) begin
		case (state_q)
			PL_FETCH_B1: begin
				op_q <= player_op_e'(rd_data);
			end
			PL_FETCH_B2: begin
				b1_q <= rd_data;
			end
			PL_EXEC: begin
				if (op_q == OP_WRITE) begin
					opm_addr <= b1_q;
					opm_data <= rd_data;
				end
			end
			default: begin
				b1_q <= b1_q;
			end
		endcase
	end

endmodule

/* design/song_rom.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

module song_rom (
	input  logic                  clk_per,
	rom_wr_if.memory              wr,
	input  logic [`YM_ROM_AW-1:0] rd_addr,
	output logic [7:0]            rd_data
);

	localparam int DEPTH = 1 << `YM_ROM_AW;

	logic [7:0] mem [DEPTH];

	// loader side, one byte per write cycle
	always_ff @(posedge clk_per) begin
		if (wr.wr_en) begin
			mem[wr.wr_addr] <= wr.wr_data;
		end
	end

	// registered read, zero while the image is still loading
	always_ff @(posedge clk_per) begin
		if (wr.prog) begin
			rd_data <= 8'h00;
		end else begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

/* design/rom_loader.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

module rom_loader import ymplayer_pkg::*; (
	input  logic                clk_per,
	input  logic                arst_n,
	input  logic                byte_valid,
	input  logic [7:0]          byte_data,
	output logic                credit_return,
	output logic                credit_error,
	output logic                load_done,
	output logic [`YM_ROM_AW:0] song_len,
	rom_wr_if.loader            wr
);

	localparam int PTR_W = $clog2(`YM_CREDITS);
	localparam int CNT_W = $clog2(`YM_CREDITS + 1);
	localparam logic [15:0] ROM_BYTES = 16'(1 << `YM_ROM_AW);

	logic [7:0]          fifo_mem [`YM_CREDITS];
	logic [PTR_W-1:0]    wr_ptr_q;
	logic [PTR_W-1:0]    rd_ptr_q;
	logic [CNT_W-1:0]    count_q;
	logic                fifo_full;
	logic                push;
	logic                pop;
	logic [7:0]          pop_data;

	loader_state_e       state_q;
	logic [7:0]          len_hi_q;
	logic [15:0]         len_word;
	logic [`YM_ROM_AW:0] addr_q;
	logic [`YM_ROM_AW:0] song_len_q;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`YM_CREDITS - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// a byte on a full buffer means the sender spent a credit it did not own
	assign fifo_full     = (count_q == CNT_W'(`YM_CREDITS));
	assign push          = byte_valid && !fifo_full;
	assign pop           = (count_q != '0);
	assign pop_data      = fifo_mem[rd_ptr_q];
	assign credit_return = pop;

	always_ff @(posedge clk_per) begin
		if (push) begin
			fifo_mem[wr_ptr_q] <= byte_data;
		end
	end

	always_ff @(posedge clk_per or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr_q     <= '0;
			rd_ptr_q     <= '0;
			count_q      <= '0;
			credit_error <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr_q <= ptr_inc(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= ptr_inc(rd_ptr_q);
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
			// sticky until reset
			if (byte_valid && fifo_full) begin
				credit_error <= 1'b1;
			end
		end
	end

	// length arrives high byte first
	assign len_word = {len_hi_q, pop_data};

	always_ff @(posedge clk_per) begin
		if (pop && state_q == LD_LEN_HI) begin
			len_hi_q <= pop_data;
		end
	end

	always_ff @(posedge clk_per or negedge arst_n) begin
		if (!arst_n) begin
			state_q    <= LD_LEN_HI;
			addr_q     <= '0;
			song_len_q <= '0;
		end else if (pop) begin
			case (state_q)
				LD_LEN_HI: begin
					state_q <= LD_LEN_LO;
				end
				LD_LEN_LO: begin
					addr_q <= '0;
					// clamp to what the ROM can hold
					if (len_word > ROM_BYTES) begin
						song_len_q <= ROM_BYTES[`YM_ROM_AW:0];
					end else begin
						song_len_q <= len_word[`YM_ROM_AW:0];
					end
					state_q <= (len_word == '0) ? LD_DONE : LD_DATA;
				end
				LD_DATA: begin
					addr_q <= addr_q + 1'b1;
					if ((addr_q + 1'b1) == song_len_q) begin
						state_q <= LD_DONE;
					end
				end
				// late bytes are drained for their credits only
				default: state_q <= LD_DONE;
			endcase
		end
	end

	assign wr.wr_en   = pop && (state_q == LD_DATA);
	assign wr.wr_addr = addr_q[`YM_ROM_AW-1:0];
	assign wr.wr_data = pop_data;
	assign wr.prog    = (state_q != LD_DONE);

	assign load_done = (state_q == LD_DONE);
	assign song_len  = song_len_q;

endmodule

/* design/rst_sync.sv */
`timescale 1ns/1ps

module rst_sync (
	input  logic clk_per,
	input  logic arst_n,
	output logic rst_n_sync
);

	logic [1:0] sync_q;

	// assert at once, release two clocks later
	always_ff @(posedge clk_per or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1};
		end
	end

	assign rst_n_sync = sync_q[1];

endmodule

/* design/rom_wr_if.sv */
`timescale 1ns/1ps
`include "ymplayer_consts.svh"

interface rom_wr_if;
	logic                  wr_en;
	logic [`YM_ROM_AW-1:0] wr_addr;
	logic [7:0]            wr_data;
	// high from reset until the whole image is in
	logic                  prog;

	modport loader (
		output wr_en,
		output wr_addr,
		output wr_data,
		output prog
	);

	modport memory (
		input wr_en,
		input wr_addr,
		input wr_data,
		input prog
	);
endinterface

/* design/ymplayer_pkg.sv */
package ymplayer_pkg;

	// command opcodes, one byte each in the song image
	// bytes outside this set stop the player like OP_END
	typedef enum logic [7:0] {
		OP_END   = 8'h00,
		OP_WRITE = 8'h01,
		OP_WAIT  = 8'h02
	} player_op_e;

	// loader walks the two length bytes, then the data bytes
	typedef enum logic [1:0] {
		LD_LEN_HI,
		LD_LEN_LO,
		LD_DATA,
		LD_DONE
	} loader_state_e;

	typedef enum logic [2:0] {
		PL_IDLE,
		PL_FETCH_OP,
		PL_FETCH_B1,
		PL_FETCH_B2,
		PL_EXEC,
		PL_WAIT,
		PL_END
	} player_state_e;

endpackage

/* design/ymplayer_consts.svh */
`ifndef YMPLAYER_CONSTS_SVH
`define YMPLAYER_CONSTS_SVH

// song ROM address width, 1024 bytes
`define YM_ROM_AW 10

// credits owned by the sender after reset, also the loader buffer depth
`define YM_CREDITS 4

// clocks per wait tick
`define YM_WAIT_TICK 4

`endif
